// File: src/drac_pkg.sv
`default_nettype none

package drac_pkg;

    // channel counts and bus widths
    localparam int NUM_MOTORS = 4;
    localparam int QUAD_W     = 32;          // one quadlet
    localparam int REG_ADDR_W = 16;          // reg_waddr / reg_raddr
    localparam int CHAN_W     = 4;           // addr bits 7:4
    localparam int DEV_W      = 4;           // addr bits 3:0
    localparam int WDOG_W     = 16;          // watchdog period and counter

    // address map
    localparam logic [CHAN_W-1:0] CHAN_BOARD      = 4'd0;  // board regs live here
    localparam logic [DEV_W-1:0]  DEV_STATUS      = 4'd0;  // bit 0 timeout, 11:8 motor count
    localparam logic [DEV_W-1:0]  DEV_WDOG_PERIOD = 4'd1;  // zero disables the watchdog
    localparam logic [DEV_W-1:0]  DEV_SETPOINT    = 4'd0;  // in channels 1..NUM_MOTORS

    // unpacker counts setpoint quadlets 0..NUM_MOTORS-1
    localparam int UNPACK_CNT_W = $clog2(NUM_MOTORS);

    // sample buffer: timestamp, status, then one quadlet per motor
    localparam int SAMPLE_QUADS  = NUM_MOTORS + 2;
    localparam int SAMPLE_ADDR_W = 6;
    localparam int SAMPLE_IDX_W  = $clog2(SAMPLE_QUADS);

    // live setpoints, motor 1 at index 0
    typedef logic [NUM_MOTORS-1:0][QUAD_W-1:0] setpoint_array_t;

    typedef enum logic [1:0] {
        UNPACK_IDLE,   // waiting for blk_wstart
        UNPACK_MASK,   // next quadlet is the motor mask
        UNPACK_DATA    // setpoint quadlets
    } unpack_state_t;

    typedef enum logic {
        SAMPLE_IDLE,
        SAMPLE_COPY    // one buffer entry per cycle
    } sample_state_t;

endpackage

`default_nettype wire

// File: src/rt_write_unpack.sv
`timescale 1ns/10ps
`default_nettype none

module rt_write_unpack (
    input  wire logic                        sysclk,
    input  wire logic                        reset,
    input  wire logic                        blk_wstart,  // opens a block
    input  wire logic                        blk_wen,     // one quadlet per strobe
    input  wire logic [drac_pkg::QUAD_W-1:0] reg_wdata,
    output logic                             rt_wen,      // one write per enabled motor
    output logic      [drac_pkg::CHAN_W-1:0] rt_waddr,    // motor number 1..N
    output logic      [drac_pkg::QUAD_W-1:0] rt_wdata,
    output logic                             bw_active    // block owns the write bus
);
    import drac_pkg::*;

    unpack_state_t           state;
    logic [NUM_MOTORS-1:0]   mask_q;     // bit i-1 enables motor i
    logic [UNPACK_CNT_W-1:0] quad_cnt;   // setpoint quadlet index
    logic                    last_quad;
    logic                    take_data;  // setpoint quadlet on the bus

    assign last_quad = (quad_cnt == UNPACK_CNT_W'(NUM_MOTORS - 1));
    assign take_data = (state == UNPACK_DATA) && blk_wen;

    // high from the start strobe through the last setpoint quadlet
    assign bw_active = blk_wstart | (state != UNPACK_IDLE);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= UNPACK_IDLE;
            mask_q   <= '0;
            quad_cnt <= '0;
            rt_wen   <= 1'b0;
            rt_waddr <= '0;
        end else begin
            rt_wen <= 1'b0;  // single-cycle strobe
            if (blk_wstart) begin
                // a new block always restarts the sequence
                state    <= UNPACK_MASK;
                quad_cnt <= '0;
            end else begin
                case (state)
                    UNPACK_MASK: begin
                        if (blk_wen) begin
                            mask_q <= reg_wdata[NUM_MOTORS-1:0];  // upper bits unused
                            state  <= UNPACK_DATA;
                        end
                    end
                    UNPACK_DATA: begin
                        if (blk_wen) begin
                            rt_wen   <= mask_q[quad_cnt];
                            rt_waddr <= CHAN_W'(quad_cnt) + 1'b1;  // motors count from 1
                            quad_cnt <= quad_cnt + 1'b1;
                            if (last_quad) begin
                                state <= UNPACK_IDLE;  // extra quadlets fall through
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // data captured with each setpoint quadlet
    always_ff @(posedge sysclk) begin
        if (take_data) begin
            rt_wdata <= reg_wdata;
        end
    end

    // a write only goes out for a motor the mask enabled
    a_rt_masked: assert property (@(posedge sysclk) disable iff (reset)
        rt_wen |-> mask_q[UNPACK_CNT_W'(rt_waddr - 1'b1)]);

    a_rt_range: assert property (@(posedge sysclk) disable iff (reset)
        rt_wen |-> (rt_waddr >= CHAN_W'(1)) && (rt_waddr <= CHAN_W'(NUM_MOTORS)));

endmodule

`default_nettype wire

// File: src/motor_regs.sv
`timescale 1ns/10ps
`default_nettype none

module motor_regs (
    input  wire logic                            sysclk,
    input  wire logic                            reset,
    input  wire logic                            reg_wen,
    input  wire logic [drac_pkg::REG_ADDR_W-1:0] reg_waddr,
    input  wire logic     [drac_pkg::QUAD_W-1:0] reg_wdata,
    input  wire logic                            bw_active,   // blocks direct writes
    input  wire logic                            rt_wen,
    input  wire logic     [drac_pkg::CHAN_W-1:0] rt_waddr,
    input  wire logic     [drac_pkg::QUAD_W-1:0] rt_wdata,
    input  wire logic [drac_pkg::REG_ADDR_W-1:0] reg_raddr,
    input  wire logic                            wdog_clear,
    output logic          [drac_pkg::QUAD_W-1:0] reg_rdata,   // one cycle after reg_raddr
    output logic                                 wdog_timeout,
    output drac_pkg::setpoint_array_t            setpoints,
    output logic          [drac_pkg::QUAD_W-1:0] status
);
    import drac_pkg::*;

    logic [CHAN_W-1:0]     wr_chan;
    logic [DEV_W-1:0]      wr_dev;
    logic [CHAN_W-1:0]     rd_chan;
    logic [DEV_W-1:0]      rd_dev;
    logic                  dir_wen;      // direct write, not during a block
    logic                  period_wr;
    logic                  status_clr;   // status write with bit 0 set
    logic                  clear_req;
    logic [NUM_MOTORS-1:0] sp_wr;        // per-motor write request
    setpoint_array_t       sp_wdata;
    logic                  sp_accept;    // some setpoint write lands this cycle
    logic [WDOG_W-1:0]     wdog_period;
    logic [WDOG_W-1:0]     wdog_cnt;     // cycles left, zero when idle
    logic                  wdog_expire;
    logic [QUAD_W-1:0]     rd_next;

    assign wr_chan = reg_waddr[CHAN_W+DEV_W-1:DEV_W];
    assign wr_dev  = reg_waddr[DEV_W-1:0];
    assign rd_chan = reg_raddr[CHAN_W+DEV_W-1:DEV_W];
    assign rd_dev  = reg_raddr[DEV_W-1:0];

    assign dir_wen    = reg_wen & ~bw_active;
    assign period_wr  = dir_wen && (wr_chan == CHAN_BOARD) && (wr_dev == DEV_WDOG_PERIOD);
    assign status_clr = dir_wen && (wr_chan == CHAN_BOARD) && (wr_dev == DEV_STATUS)
                        && reg_wdata[0];
    assign clear_req  = wdog_clear | status_clr;

    // motor count in 11:8, timeout flag in bit 0
    assign status = {16'd0, 4'd0, 4'(NUM_MOTORS), 7'd0, wdog_timeout};

    // real-time write wins if both hit the same motor
    always_comb begin
        sp_wr    = '0;
        sp_wdata = '0;
        for (int i = 1; i <= NUM_MOTORS; i++) begin
            if (rt_wen && (rt_waddr == CHAN_W'(i))) begin
                sp_wr[i-1]    = 1'b1;
                sp_wdata[i-1] = rt_wdata;
            end else if (dir_wen && (wr_chan == CHAN_W'(i)) && (wr_dev == DEV_SETPOINT)) begin
                sp_wr[i-1]    = 1'b1;
                sp_wdata[i-1] = reg_wdata;
            end
        end
    end

    assign sp_accept = (|sp_wr) & ~wdog_timeout;  // dropped while timed out

    // last count with nothing reloading it
    assign wdog_expire = ~wdog_timeout && (wdog_cnt == WDOG_W'(1))
                         && ~sp_accept && ~period_wr && ~clear_req;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_period <= '0;
            wdog_cnt    <= '0;
        end else begin
            if (period_wr) begin
                wdog_period <= reg_wdata[WDOG_W-1:0];
            end
            if (period_wr) begin
                wdog_cnt <= reg_wdata[WDOG_W-1:0];  // count from the period write
            end else if (sp_accept || clear_req) begin
                wdog_cnt <= wdog_period;
            end else if (!wdog_timeout && (wdog_cnt != '0)) begin
                wdog_cnt <= wdog_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_timeout <= 1'b0;
        end else if (clear_req) begin
            wdog_timeout <= 1'b0;
        end else if (wdog_expire) begin
            wdog_timeout <= 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            setpoints <= '0;
        end else if (wdog_expire) begin
            setpoints <= '0;  // motors stop on timeout
        end else if (!wdog_timeout) begin
            for (int i = 0; i < NUM_MOTORS; i++) begin
                if (sp_wr[i]) begin
                    setpoints[i] <= sp_wdata[i];
                end
            end
        end
    end

    // read mux; unmapped reads zero
    always_comb begin
        rd_next = '0;
        if (rd_chan == CHAN_BOARD) begin
            if (rd_dev == DEV_STATUS) begin
                rd_next = status;
            end else if (rd_dev == DEV_WDOG_PERIOD) begin
                rd_next = {16'd0, wdog_period};
            end
        end
        for (int i = 1; i <= NUM_MOTORS; i++) begin
            if ((rd_chan == CHAN_W'(i)) && (rd_dev == DEV_SETPOINT)) begin
                rd_next = setpoints[i-1];
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

    // setpoints can only fall to zero while timed out
    a_locked: assert property (@(posedge sysclk) disable iff (reset)
        wdog_timeout && !$stable(setpoints) |-> (setpoints == '0));

endmodule

`default_nettype wire

// File: src/sample_capture.sv
`timescale 1ns/10ps
`default_nettype none

module sample_capture (
    input  wire logic                               sysclk,
    input  wire logic                               reset,
    input  wire logic                               sample_start,
    input  wire logic        [drac_pkg::QUAD_W-1:0] timestamp,
    input  wire logic        [drac_pkg::QUAD_W-1:0] status,
    input  wire drac_pkg::setpoint_array_t          setpoints,
    input  wire logic [drac_pkg::SAMPLE_ADDR_W-1:0] sample_raddr,
    output logic                                    sample_busy,
    output logic             [drac_pkg::QUAD_W-1:0] sample_rdata
);
    import drac_pkg::*;

    sample_state_t     state;
    logic [SAMPLE_IDX_W-1:0] copy_idx;                    // buffer entry being written
    logic [QUAD_W-1:0] ts_latch;                          // timestamp at start
    logic [QUAD_W-1:0] sample_buf [SAMPLE_QUADS];
    logic [QUAD_W-1:0] copy_data;
    logic              copy_last;

    assign sample_busy = (state == SAMPLE_COPY);
    assign copy_last   = (copy_idx == SAMPLE_IDX_W'(SAMPLE_QUADS - 1));

    // entry 0 timestamp, 1 status, then live setpoints
    always_comb begin
        copy_data = '0;
        if (copy_idx == SAMPLE_IDX_W'(0)) begin
            copy_data = ts_latch;
        end else if (copy_idx == SAMPLE_IDX_W'(1)) begin
            copy_data = status;
        end
        for (int i = 0; i < NUM_MOTORS; i++) begin
            if (copy_idx == SAMPLE_IDX_W'(i + 2)) begin
                copy_data = setpoints[i];
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= SAMPLE_IDLE;
            copy_idx <= '0;
        end else begin
            case (state)
                SAMPLE_IDLE: begin
                    if (sample_start) begin
                        state    <= SAMPLE_COPY;
                        copy_idx <= '0;
                    end
                end
                SAMPLE_COPY: begin
                    // start pulses are ignored in here
                    copy_idx <= copy_idx + 1'b1;
                    if (copy_last) begin
                        state <= SAMPLE_IDLE;
                    end
                end
                default: state <= SAMPLE_IDLE;
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if ((state == SAMPLE_IDLE) && sample_start) begin
            ts_latch <= timestamp;  // same cycle as the start
        end
    end

    // buffer starts out zero
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < SAMPLE_QUADS; i++) begin
                sample_buf[i] <= '0;
            end
        end else if (sample_busy) begin
            sample_buf[copy_idx] <= copy_data;
        end
    end

    // registered read port
    always_ff @(posedge sysclk) begin
        if (reset) begin
            sample_rdata <= '0;
        end else if (sample_raddr < SAMPLE_ADDR_W'(SAMPLE_QUADS)) begin
            sample_rdata <= sample_buf[sample_raddr[SAMPLE_IDX_W-1:0]];
        end else begin
            sample_rdata <= '0;  // past the end
        end
    end

    a_busy_len: assert property (@(posedge sysclk) disable iff (reset)
        $rose(sample_busy) |-> sample_busy [*SAMPLE_QUADS] ##1 !sample_busy);

endmodule

`default_nettype wire

// File: src/drac_core.sv
`timescale 1ns/10ps
`default_nettype none

module drac_core (
    input  wire logic                               sysclk,
    input  wire logic                               reset,
    input  wire logic                               reg_wen,
    input  wire logic    [drac_pkg::REG_ADDR_W-1:0] reg_waddr,
    input  wire logic        [drac_pkg::QUAD_W-1:0] reg_wdata,
    input  wire logic    [drac_pkg::REG_ADDR_W-1:0] reg_raddr,
    input  wire logic                               blk_wstart,
    input  wire logic                               blk_wen,
    input  wire logic                               wdog_clear,
    input  wire logic                               sample_start,
    input  wire logic [drac_pkg::SAMPLE_ADDR_W-1:0] sample_raddr,
    input  wire logic        [drac_pkg::QUAD_W-1:0] timestamp,
    output logic             [drac_pkg::QUAD_W-1:0] reg_rdata,
    output logic                                    wdog_timeout,
    output logic                                    sample_busy,
    output logic             [drac_pkg::QUAD_W-1:0] sample_rdata
);
    import drac_pkg::*;

    // real-time writes out of the unpacker
    logic              rt_wen;
    logic [CHAN_W-1:0] rt_waddr;
    logic [QUAD_W-1:0] rt_wdata;
    logic              bw_active;

    // live state for the sampler
    setpoint_array_t   setpoints;
    logic [QUAD_W-1:0] status;

    rt_write_unpack i_unpack (
        .sysclk     (sysclk),
        .reset      (reset),
        .blk_wstart (blk_wstart),
        .blk_wen    (blk_wen),
        .reg_wdata  (reg_wdata),
        .rt_wen     (rt_wen),
        .rt_waddr   (rt_waddr),
        .rt_wdata   (rt_wdata),
        .bw_active  (bw_active)
    );

    motor_regs i_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .bw_active    (bw_active),
        .rt_wen       (rt_wen),
        .rt_waddr     (rt_waddr),
        .rt_wdata     (rt_wdata),
        .reg_raddr    (reg_raddr),
        .wdog_clear   (wdog_clear),
        .reg_rdata    (reg_rdata),
        .wdog_timeout (wdog_timeout),
        .setpoints    (setpoints),
        .status       (status)
    );

    sample_capture i_sample (
        .sysclk       (sysclk),
        .reset        (reset),
        .sample_start (sample_start),
        .timestamp    (timestamp),
        .status       (status),
        .setpoints    (setpoints),
        .sample_raddr (sample_raddr),
        .sample_busy  (sample_busy),
        .sample_rdata (sample_rdata)
    );

endmodule

`default_nettype wire

// File: tb/drac_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module drac_core_tb;
    import drac_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] LFSR_SEED    = 32'h3f6e;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32+x^22+x^2+x+1
    localparam int          WDOG_TEST    = 40;             // period for the timeout tests
    localparam int          WDOG_MARGIN  = 4;
    localparam int          WAIT_LIMIT   = 100;

    logic                     sysclk;
    logic                     reset;
    logic                     reg_wen;
    logic [REG_ADDR_W-1:0]    reg_waddr;
    logic [QUAD_W-1:0]        reg_wdata;
    logic [REG_ADDR_W-1:0]    reg_raddr;
    logic                     blk_wstart;
    logic                     blk_wen;
    logic                     wdog_clear;
    logic                     sample_start;
    logic [SAMPLE_ADDR_W-1:0] sample_raddr;
    logic [QUAD_W-1:0]        timestamp;
    logic [QUAD_W-1:0]        reg_rdata;
    logic                     wdog_timeout;
    logic                     sample_busy;
    logic [QUAD_W-1:0]        sample_rdata;

    logic [QUAD_W-1:0] sb [NUM_MOTORS];  // setpoint mirror with motor 1 at index 0
    logic [31:0]       lfsr;

    // expected read data delayed one cycle to meet the registered read ports
    logic              rd_chk, rd_chk_q;
    logic [QUAD_W-1:0] rd_exp, rd_exp_q;
    logic              sm_chk, sm_chk_q;
    logic [QUAD_W-1:0] sm_exp, sm_exp_q;
    logic              wdog_chk, wdog_exp;  // expected timeout flag
    logic              tmo_chk, start_chk, len_chk;
    int                tmo_cycles;          // cycles from period write to timeout
    int                busy_len;
    int                err_reg, err_sample, err_wdog, err_tmo, err_busy, err_wait;
    int                check_count;
    int                errs_before;

    drac_core i_dut (
        .sysclk       (sysclk),
        .reset        (reset),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_raddr    (reg_raddr),
        .blk_wstart   (blk_wstart),
        .blk_wen      (blk_wen),
        .wdog_clear   (wdog_clear),
        .sample_start (sample_start),
        .sample_raddr (sample_raddr),
        .timestamp    (timestamp),
        .reg_rdata    (reg_rdata),
        .wdog_timeout (wdog_timeout),
        .sample_busy  (sample_busy),
        .sample_rdata (sample_rdata)
    );

    initial begin
        sysclk = 1'b0;
        forever #(CLK_PERIOD/2) sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        rd_chk_q <= rd_chk;
        rd_exp_q <= rd_exp;
        sm_chk_q <= sm_chk;
        sm_exp_q <= sm_exp;
    end

    a_reg_rdata: assert property (@(posedge sysclk) disable iff (reset)
        rd_chk_q |-> (reg_rdata == rd_exp_q))
    else begin
        err_reg++;
        $display("Error at %0t: reg_rdata expected %h, got %h",
                 $time, $sampled(rd_exp_q), $sampled(reg_rdata));
    end

    a_sample_rdata: assert property (@(posedge sysclk) disable iff (reset)
        sm_chk_q |-> (sample_rdata == sm_exp_q))
    else begin
        err_sample++;
        $display("Error at %0t: sample_rdata expected %h, got %h",
                 $time, $sampled(sm_exp_q), $sampled(sample_rdata));
    end

    a_wdog_flag: assert property (@(posedge sysclk) disable iff (reset)
        wdog_chk |-> (wdog_timeout == wdog_exp))
    else begin
        err_wdog++;
        $display("Error at %0t: wdog_timeout expected %b, got %b",
                 $time, $sampled(wdog_exp), $sampled(wdog_timeout));
    end

    a_wdog_window: assert property (@(posedge sysclk) disable iff (reset)
        tmo_chk |-> (tmo_cycles >= WDOG_TEST) && (tmo_cycles <= WDOG_TEST + WDOG_MARGIN))
    else begin
        err_tmo++;
        $display("Error at %0t: wdog_timeout rise expected after %0d..%0d cycles, got %0d",
                 $time, WDOG_TEST, WDOG_TEST + WDOG_MARGIN, $sampled(tmo_cycles));
    end

    a_busy_rise: assert property (@(posedge sysclk) disable iff (reset)
        start_chk |=> sample_busy)
    else begin
        err_busy++;
        $display("Error at %0t: sample_busy expected 1, got %b", $time, $sampled(sample_busy));
    end

    a_busy_len: assert property (@(posedge sysclk) disable iff (reset)
        len_chk |-> (busy_len == SAMPLE_QUADS))
    else begin
        err_busy++;
        $display("Error at %0t: sample_busy length expected %0d, got %0d",
                 $time, SAMPLE_QUADS, $sampled(busy_len));
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ LFSR_TAPS;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] sp_addr(input int motor);
        return {8'h00, 4'(motor), 4'h0};  // device 0 of the motor's channel
    endfunction

    // status word as the register map defines it
    function automatic logic [QUAD_W-1:0] status_exp(input logic tmo);
        logic [QUAD_W-1:0] s;
        s       = '0;
        s[11:8] = 4'd4;  // four motor channels
        s[0]    = tmo;
        return s;
    endfunction

    function automatic int total_errors();
        return err_reg + err_sample + err_wdog + err_tmo + err_busy + err_wait;
    endfunction

    // every task starts and ends 1 ns after a rising edge
    task automatic step();
        @(posedge sysclk);
        #1;
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [QUAD_W-1:0] data);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        step();
        reg_wen   = 1'b0;
    endtask

    task automatic check_reg(input logic [REG_ADDR_W-1:0] addr, input logic [QUAD_W-1:0] exp);
        reg_raddr = addr;
        rd_exp    = exp;
        rd_chk    = 1'b1;
        check_count++;
        step();
        rd_chk    = 1'b0;
    endtask

    task automatic check_sample(input int addr, input logic [QUAD_W-1:0] exp);
        sample_raddr = SAMPLE_ADDR_W'(addr);
        sm_exp       = exp;
        sm_chk       = 1'b1;
        check_count++;
        step();
        sm_chk       = 1'b0;
    endtask

    task automatic check_setpoints();
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            check_reg(sp_addr(m), sb[m-1]);
        end
    endtask

    // poll wdog_timeout until it reaches level or the limit runs out
    task automatic wait_wdog(input logic level, input int limit, output int cycles);
        cycles = 0;
        while ((wdog_timeout !== level) && (cycles < limit)) begin
            step();
            cycles++;
        end
        if (wdog_timeout !== level) begin
            err_wait++;
            $display("wdog_timeout never reached %b within %0d cycles", level, limit);
        end
    endtask

    task automatic end_test(input string name);
        step();  // let the last registered check fire
        step();
        $display("test %-16s done, %0d errors", name, total_errors() - errs_before);
        errs_before = total_errors();
    endtask

    initial begin
        int               n;
        int               tgt;
        logic [QUAD_W-1:0] ts;
        logic [QUAD_W-1:0] mask_q;
        logic [QUAD_W-1:0] d;
        logic [15:0]      period;

        reset = 1'b1;
        reg_wen = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        blk_wstart = 1'b0;
        blk_wen = 1'b0;
        wdog_clear = 1'b0;
        sample_start = 1'b0;
        sample_raddr = '0;
        timestamp = '0;
        rd_chk = 1'b0;
        rd_exp = '0;
        sm_chk = 1'b0;
        sm_exp = '0;
        wdog_chk = 1'b0;
        wdog_exp = 1'b0;
        tmo_chk = 1'b0;
        start_chk = 1'b0;
        len_chk = 1'b0;
        tmo_cycles = 0;
        busy_len = 0;
        err_reg = 0;
        err_sample = 0;
        err_wdog = 0;
        err_tmo = 0;
        err_busy = 0;
        err_wait = 0;
        check_count = 0;
        errs_before = 0;
        lfsr = LFSR_SEED;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            sb[m] = '0;
        end

        repeat (RESET_CYCLES) @(posedge sysclk);
        #1;
        reset = 1'b0;
        wdog_chk = 1'b1;  // timeout low out of reset

        // direct writes and read-back
        check_setpoints();  // all zero after reset
        check_reg(16'h0000, status_exp(1'b0));
        for (int m = 1; m <= NUM_MOTORS; m++) begin
            sb[m-1] = rand_bits(32);
            write_reg(sp_addr(m), sb[m-1]);
        end
        period = 16'h8000 | 16'(rand_bits(15));  // long enough to stay quiet
        write_reg(16'h0001, {16'd0, period});
        check_setpoints();
        check_reg(16'h0001, {16'd0, period});
        check_reg(16'ha510, sb[0]);               // upper byte ignored
        check_reg(16'h0005, '0);
        check_reg(16'h0011, '0);
        check_reg(16'h0070, '0);                  // past the last motor
        end_test("direct_writes");

        // block write with one direct write aimed at an unmasked motor
        tgt = int'(rand_bits(2));
        mask_q = rand_bits(32);
        mask_q[tgt] = 1'b0;
        blk_wstart = 1'b1;
        step();
        blk_wstart = 1'b0;
        blk_wen = 1'b1;
        reg_wdata = mask_q;
        reg_wen = 1'b1;
        reg_waddr = sp_addr(tgt + 1);
        step();
        reg_wen = 1'b0;
        for (int i = 0; i < NUM_MOTORS; i++) begin
            d = rand_bits(32);
            reg_wdata = d;
            if (mask_q[i]) begin
                sb[i] = d;
            end
            step();
        end
        reg_wdata = rand_bits(32);  // trailing quadlet has no effect
        step();
        blk_wen = 1'b0;
        step();
        check_setpoints();
        end_test("block_write");

        // watchdog timeout
        wdog_chk = 1'b0;
        write_reg(16'h0001, WDOG_TEST);
        wait_wdog(1'b1, WDOG_TEST + WDOG_MARGIN, n);
        tmo_cycles = n;
        tmo_chk = 1'b1;
        wdog_exp = 1'b1;
        wdog_chk = 1'b1;
        check_count++;
        step();
        tmo_chk = 1'b0;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            sb[m] = '0;
        end
        write_reg(sp_addr(2), rand_bits(32));  // dropped while locked
        check_setpoints();
        check_reg(16'h0000, status_exp(1'b1));
        end_test("wdog_timeout");

        // clear by pulse and then by status write
        wdog_clear = 1'b1;
        step();
        wdog_clear = 1'b0;
        wdog_exp = 1'b0;
        check_reg(16'h0000, status_exp(1'b0));
        sb[2] = rand_bits(32);
        write_reg(sp_addr(3), sb[2]);
        check_setpoints();
        wdog_chk = 1'b0;
        wait_wdog(1'b1, WDOG_TEST + WDOG_MARGIN, n);
        wdog_exp = 1'b1;
        wdog_chk = 1'b1;
        for (int m = 0; m < NUM_MOTORS; m++) begin
            sb[m] = '0;
        end
        write_reg(16'h0000, 32'h1);
        wdog_exp = 1'b0;
        write_reg(16'h0001, '0);  // watchdog off for the rest
        sb[0] = rand_bits(32);
        write_reg(sp_addr(1), sb[0]);
        check_setpoints();
        check_reg(16'h0000, status_exp(1'b0));
        end_test("wdog_clear");

        // sampling with a second start while busy
        ts = rand_bits(32);
        timestamp = ts;
        sample_start = 1'b1;
        start_chk = 1'b1;
        check_count++;
        step();
        sample_start = 1'b0;
        start_chk = 1'b0;
        n = 0;
        while (sample_busy && (n < WAIT_LIMIT)) begin
            sample_start = (n == 2);
            if (n == 2) begin
                timestamp = ~ts;
            end
            step();
            n++;
        end
        sample_start = 1'b0;
        if (sample_busy) begin
            err_wait++;
            $display("sample_busy stuck high for %0d cycles", WAIT_LIMIT);
        end
        busy_len = n;
        len_chk = 1'b1;
        check_count++;
        step();
        len_chk = 1'b0;
        check_sample(0, ts);
        check_sample(1, status_exp(1'b0));
        for (int i = 0; i < NUM_MOTORS; i++) begin
            check_sample(i + 2, sb[i]);
        end
        end_test("sampling");

        $display("summary: 5 tests, %0d checks, %0d errors", check_count, total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: drac_core.f
src/drac_pkg.sv
src/rt_write_unpack.sv
src/motor_regs.sv
src/sample_capture.sv
src/drac_core.sv
tb/drac_core_tb.sv

// File: Makefile
# Verilator build and run of the drac_core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module drac_core_tb \
		-f drac_core.f -o drac_core_sim
	./obj_dir/drac_core_sim | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
